// File: hci_queues_defines.svh
/* Register map, queue sizing and threshold reset values for the HCI command and
   response queues. Include wherever offsets or widths are needed. */
`ifndef HCI_QUEUES_DEFINES_SVH
`define HCI_QUEUES_DEFINES_SVH

// Queue sizing
`define HCI_QUEUE_DEPTH 16
`define HCI_COUNT_W 5
`define HCI_THLD_W 8

`define HCI_ADDR_W 8

// Register offsets
`define HCI_COMMAND_PORT 8'h00
`define HCI_RESPONSE_PORT 8'h04
`define HCI_QUEUE_THLD_CTRL 8'h08
`define HCI_RESET_CONTROL 8'h0C
`define HCI_QUEUE_STATUS 8'h10

// QUEUE_THLD_CTRL fields
`define HCI_CMD_THLD_LSB 0 // Command empty-space threshold
`define HCI_RESP_THLD_LSB 8 // Response ready threshold

// RESET_CONTROL bits, self-clearing
`define HCI_CMD_RST_BIT 0
`define HCI_RESP_RST_BIT 1

// Threshold reset values
`define HCI_CMD_THLD_RST 1
`define HCI_RESP_THLD_RST 1

`endif

// File: hci_queues_pkg.sv
/* Word, descriptor and count types shared by the queue RTL and its testbench.
   Import by wildcard in the module header. */
`include "hci_queues_defines.svh"

package hci_queues_pkg;

  // One APB register or port word
  typedef logic [31:0] csr_word_t;

  // Command descriptor, first written word in the low half
  typedef logic [63:0] cmd_desc_t;

  typedef logic [31:0] resp_desc_t;

  // Fill level, holds 0 up to the full depth
  typedef logic [`HCI_COUNT_W-1:0] queue_count_t;

  typedef logic [`HCI_THLD_W-1:0] queue_thld_t;

endpackage

// File: hci_csr_regs.sv
/* APB register file for the HCI queues. Decodes port and control accesses, keeps
   the thresholds and self-clearing flush bits, and reports queue status. */
`timescale 1ns/100ps
`include "hci_queues_defines.svh"

module hci_csr_regs
  import hci_queues_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // APB, zero wait states
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`HCI_ADDR_W-1:0] paddr_i,
  input  csr_word_t              pwdata_i,
  output csr_word_t              prdata_o,
  output logic                   pslverr_o,

  // Command queue
  output logic                   cmd_word_wr_o,
  output csr_word_t              cmd_word_o,
  output logic                   cmd_flush_o,
  output queue_thld_t            cmd_thld_o,

  // Response queue
  output logic                   resp_pop_o,
  output logic                   resp_flush_o,
  output queue_thld_t            resp_thld_o,

  input  queue_count_t           cmd_count_i,
  input  queue_count_t           resp_count_i,
  input  resp_desc_t             resp_head_i
);

  localparam queue_count_t depth = queue_count_t'(`HCI_QUEUE_DEPTH);
  localparam queue_thld_t max_thld = queue_thld_t'(`HCI_QUEUE_DEPTH);

  logic        access, wr, rd;
  logic        sel_cmd, sel_resp, sel_thld, sel_rst, sel_status;
  logic        cmd_full, cmd_empty, resp_full, resp_empty;
  queue_thld_t cmd_thld_q, resp_thld_q;
  logic        cmd_rst_q, resp_rst_q;
  csr_word_t   status;

  function automatic queue_thld_t clamp_thld(input queue_thld_t value);
    return (value > max_thld) ? max_thld : value;
  endfunction

  assign access = psel_i && penable_i;
  assign wr     = access && pwrite_i;
  assign rd     = access && !pwrite_i;

  assign sel_cmd    = (paddr_i == `HCI_COMMAND_PORT);
  assign sel_resp   = (paddr_i == `HCI_RESPONSE_PORT);
  assign sel_thld   = (paddr_i == `HCI_QUEUE_THLD_CTRL);
  assign sel_rst    = (paddr_i == `HCI_RESET_CONTROL);
  assign sel_status = (paddr_i == `HCI_QUEUE_STATUS);

  assign cmd_full   = (cmd_count_i == depth);
  assign cmd_empty  = (cmd_count_i == '0);
  assign resp_full  = (resp_count_i == depth);
  assign resp_empty = (resp_count_i == '0);

  // Port side effects only on accesses without error
  assign cmd_word_wr_o = wr && sel_cmd && !cmd_full;
  assign cmd_word_o    = pwdata_i;
  assign resp_pop_o    = rd && sel_resp && !resp_empty;

  assign pslverr_o = access && ((wr && sel_cmd && cmd_full) ||
                                (rd && sel_resp && resp_empty) ||
                                !(sel_cmd || sel_resp || sel_thld || sel_rst || sel_status));

  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;
  assign cmd_flush_o  = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= queue_thld_t'(`HCI_CMD_THLD_RST);
      resp_thld_q <= queue_thld_t'(`HCI_RESP_THLD_RST);
    end else if (wr && sel_thld) begin
      cmd_thld_q  <= clamp_thld(pwdata_i[`HCI_CMD_THLD_LSB +: `HCI_THLD_W]);
      resp_thld_q <= clamp_thld(pwdata_i[`HCI_RESP_THLD_LSB +: `HCI_THLD_W]);
    end
  end

  // Flush bits live one cycle, then clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q  <= 1'b0;
      resp_rst_q <= 1'b0;
    end else if (wr && sel_rst) begin
      cmd_rst_q  <= pwdata_i[`HCI_CMD_RST_BIT];
      resp_rst_q <= pwdata_i[`HCI_RESP_RST_BIT];
    end else begin
      cmd_rst_q  <= 1'b0;
      resp_rst_q <= 1'b0;
    end
  end

  always_comb begin
    status = '0;
    status[0 +: `HCI_COUNT_W] = cmd_count_i;
    status[8 +: `HCI_COUNT_W] = resp_count_i;
    status[16] = cmd_full;
    status[17] = cmd_empty;
    status[18] = resp_full;
    status[19] = resp_empty;
  end

  always_comb begin
    prdata_o = '0;
    if (rd) begin
      if (sel_resp && !resp_empty) begin
        prdata_o = resp_head_i;
      end else if (sel_thld) begin
        prdata_o[`HCI_CMD_THLD_LSB +: `HCI_THLD_W]  = cmd_thld_q;
        prdata_o[`HCI_RESP_THLD_LSB +: `HCI_THLD_W] = resp_thld_q;
      end else if (sel_rst) begin
        prdata_o[`HCI_CMD_RST_BIT]  = cmd_rst_q;
        prdata_o[`HCI_RESP_RST_BIT] = resp_rst_q;
      end else if (sel_status) begin
        prdata_o = status;
      end
    end
  end

  a_addr_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    psel_i |-> (paddr_i[1:0] == 2'b00)
  );

endmodule

// File: hci_cmd_queue.sv
/* Command queue. Pairs two 32-bit COMMAND_PORT writes into one 64-bit descriptor
   and hands whole descriptors to the controller over valid/ready. */
`timescale 1ns/100ps
`include "hci_queues_defines.svh"

module hci_cmd_queue
  import hci_queues_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // From the register file
  input  logic         word_wr_i,
  input  csr_word_t    word_i,
  input  logic         flush_i,
  input  queue_thld_t  thld_i,

  // To the controller
  output logic         cmd_valid_o,
  input  logic         cmd_ready_i,
  output cmd_desc_t    cmd_data_o,

  output queue_count_t count_o,
  output logic         thld_trig_o
);

  localparam int ptr_w = $clog2(`HCI_QUEUE_DEPTH);
  localparam queue_count_t depth = queue_count_t'(`HCI_QUEUE_DEPTH);

  cmd_desc_t          mem_q [`HCI_QUEUE_DEPTH];
  logic [ptr_w-1:0]   wr_ptr_q;
  logic [ptr_w-1:0]   rd_ptr_q;
  queue_count_t       count_q;
  queue_count_t       free_cnt;

  csr_word_t          half_q; // First word of a pending command
  logic               phase_q; // High once the low half is held

  logic               full;
  logic               push;
  logic               pop;

  assign full = (count_q == depth);

  // Second word completes the descriptor
  assign push = word_wr_i && phase_q && !flush_i;
  assign pop  = cmd_valid_o && cmd_ready_i && !flush_i;

  assign cmd_valid_o = (count_q != '0);
  assign cmd_data_o  = mem_q[rd_ptr_q];
  assign count_o     = count_q;

  assign free_cnt    = depth - count_q;
  assign thld_trig_o = queue_thld_t'(free_cnt) >= thld_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else if (flush_i) begin
      phase_q <= 1'b0; // Next write starts a fresh command
    end else if (word_wr_i) begin
      phase_q <= !phase_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_wr_i && !phase_q) begin
      half_q <= word_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {word_i, half_q};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Both or neither
      endcase
    end
  end

  // Register file must drop port writes once the queue is full
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (word_wr_i && phase_q) |-> !full
  );

endmodule

// File: hci_resp_queue.sv
/* Response queue. Accepts controller responses over valid/ready and returns them
   in order to RESPONSE_PORT reads. */
`timescale 1ns/100ps
`include "hci_queues_defines.svh"

module hci_resp_queue
  import hci_queues_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // From the controller
  input  logic         resp_valid_i,
  output logic         resp_ready_o,
  input  resp_desc_t   resp_data_i,

  // Register file side
  input  logic         pop_i,
  input  logic         flush_i,
  input  queue_thld_t  thld_i,
  output resp_desc_t   head_o,
  output queue_count_t count_o,
  output logic         thld_trig_o
);

  localparam int ptr_w = $clog2(`HCI_QUEUE_DEPTH);
  localparam queue_count_t depth = queue_count_t'(`HCI_QUEUE_DEPTH);

  resp_desc_t         mem_q [`HCI_QUEUE_DEPTH];
  logic [ptr_w-1:0]   wr_ptr_q;
  logic [ptr_w-1:0]   rd_ptr_q;
  queue_count_t       count_q;
  logic               push;
  logic               pop;

  // Hold off the controller during a flush so no response is lost silently
  assign resp_ready_o = (count_q != depth) && !flush_i;
  assign push         = resp_valid_i && resp_ready_o;
  assign pop          = pop_i && !flush_i;

  assign head_o      = mem_q[rd_ptr_q];
  assign count_o     = count_q;
  assign thld_trig_o = (count_q != '0) && (queue_thld_t'(count_q) >= thld_i);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= resp_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Register file only pops what is there
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (count_q != '0)
  );

endmodule

// File: hci_queues_top.sv
/* Top level of the HCI command and response queues. Connects the APB register
   file to both queues. */
`timescale 1ns/100ps
`include "hci_queues_defines.svh"

module hci_queues_top
  import hci_queues_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // APB
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`HCI_ADDR_W-1:0] paddr_i,
  input  csr_word_t              pwdata_i,
  output csr_word_t              prdata_o,
  output logic                   pslverr_o,

  // Commands to the controller
  output logic                   cmd_valid_o,
  input  logic                   cmd_ready_i,
  output cmd_desc_t              cmd_data_o,

  // Responses from the controller
  input  logic                   resp_valid_i,
  output logic                   resp_ready_o,
  input  resp_desc_t             resp_data_i,

  output logic                   cmd_thld_trig_o,
  output logic                   resp_thld_trig_o
);

  logic         cmd_word_wr, cmd_flush, resp_pop, resp_flush;
  csr_word_t    cmd_word;
  queue_thld_t  cmd_thld, resp_thld;
  queue_count_t cmd_count, resp_count;
  resp_desc_t   resp_head;

  hci_csr_regs u_csr (
    .clk_i, .rst_ni,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i, .prdata_o, .pslverr_o,
    .cmd_word_wr_o (cmd_word_wr),
    .cmd_word_o    (cmd_word),
    .cmd_flush_o   (cmd_flush),
    .cmd_thld_o    (cmd_thld),
    .resp_pop_o    (resp_pop),
    .resp_flush_o  (resp_flush),
    .resp_thld_o   (resp_thld),
    .cmd_count_i   (cmd_count),
    .resp_count_i  (resp_count),
    .resp_head_i   (resp_head)
  );

  hci_cmd_queue u_cmd_queue (
    .clk_i, .rst_ni,
    .word_wr_i   (cmd_word_wr),
    .word_i      (cmd_word),
    .flush_i     (cmd_flush),
    .thld_i      (cmd_thld),
    .cmd_valid_o, .cmd_ready_i, .cmd_data_o,
    .count_o     (cmd_count),
    .thld_trig_o (cmd_thld_trig_o)
  );

  hci_resp_queue u_resp_queue (
    .clk_i, .rst_ni,
    .resp_valid_i, .resp_ready_o, .resp_data_i,
    .pop_i       (resp_pop),
    .flush_i     (resp_flush),
    .thld_i      (resp_thld),
    .head_o      (resp_head),
    .count_o     (resp_count),
    .thld_trig_o (resp_thld_trig_o)
  );

endmodule

// File: tb_hci_queues.sv
/* Self-checking testbench for hci_queues_top. Drives APB and both controller
   sides and compares against a reference model of the two queues. */
`timescale 1ns/100ps
`include "hci_queues_defines.svh"

module tb_hci_queues
  import hci_queues_pkg::*;
();

  localparam logic [31:0] seed = 32'h7a865f5d;
  localparam int timeout_cycles = 200;
  localparam int depth = `HCI_QUEUE_DEPTH;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`HCI_ADDR_W-1:0] paddr_i;
  csr_word_t              pwdata_i;
  csr_word_t              prdata_o;
  logic                   pslverr_o;
  logic                   cmd_valid_o;
  logic                   cmd_ready_i = 1'b0;
  cmd_desc_t              cmd_data_o;
  logic                   resp_valid_i;
  logic                   resp_ready_o;
  resp_desc_t             resp_data_i;
  logic                   cmd_thld_trig_o;
  logic                   resp_thld_trig_o;

  // Reference model state
  cmd_desc_t   cmd_model [$];
  resp_desc_t  resp_model [$];
  csr_word_t   half_m; // Low half of a pending command
  logic        phase_m;
  queue_thld_t cmd_thld_m;
  queue_thld_t resp_thld_m;
  cmd_desc_t   exp_desc;

  int          errors;
  int          checks;
  logic [31:0] lcg_state;
  logic [31:0] ready_state;
  logic        ready_random; // Random ready pattern when set
  logic        ready_hold;

  always #10 clk_i = ~clk_i;

  hci_queues_top UUT (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic [31:0] next_rand();
    lcg_state = lcg_next(lcg_state);
    return lcg_state;
  endfunction

  // Expected {pslverr, prdata} of an access before it commits
  function automatic logic [32:0] ref_access(input logic [7:0] addr, input logic write);
    csr_word_t data;
    logic      err;
    int        nc;
    int        nr;
    data = '0;
    err  = 1'b0;
    nc   = cmd_model.size();
    nr   = resp_model.size();
    case (addr)
      `HCI_COMMAND_PORT: err = write && (nc == depth);
      `HCI_RESPONSE_PORT: begin
        if (!write && nr == 0) begin
          err = 1'b1;
        end else if (!write) begin
          data = resp_model[0];
        end
      end
      `HCI_QUEUE_THLD_CTRL: begin
        if (!write) begin
          data[`HCI_CMD_THLD_LSB +: `HCI_THLD_W]  = cmd_thld_m;
          data[`HCI_RESP_THLD_LSB +: `HCI_THLD_W] = resp_thld_m;
        end
      end
      `HCI_RESET_CONTROL: data = '0; // Self-cleared before any read
      `HCI_QUEUE_STATUS: begin
        if (!write) begin
          data[4:0]  = queue_count_t'(nc);
          data[12:8] = queue_count_t'(nr);
          data[16]   = (nc == depth);
          data[17]   = (nc == 0);
          data[18]   = (nr == depth);
          data[19]   = (nr == 0);
        end
      end
      default: err = 1'b1;
    endcase
    return {err, data};
  endfunction

  task automatic model_commit(input logic [7:0] addr, input logic write,
                              input csr_word_t wdata, input logic err);
    if (!err) begin
      if (write && addr == `HCI_COMMAND_PORT) begin
        if (phase_m) begin
          cmd_model.push_back({wdata, half_m});
        end else begin
          half_m = wdata;
        end
        phase_m = !phase_m;
      end else if (write && addr == `HCI_QUEUE_THLD_CTRL) begin
        cmd_thld_m  = (wdata[`HCI_CMD_THLD_LSB +: 8] > depth) ?
                      queue_thld_t'(depth) : wdata[`HCI_CMD_THLD_LSB +: 8];
        resp_thld_m = (wdata[`HCI_RESP_THLD_LSB +: 8] > depth) ?
                      queue_thld_t'(depth) : wdata[`HCI_RESP_THLD_LSB +: 8];
      end else if (write && addr == `HCI_RESET_CONTROL) begin
        if (wdata[`HCI_CMD_RST_BIT]) begin
          cmd_model.delete();
          phase_m = 1'b0;
        end
        if (wdata[`HCI_RESP_RST_BIT]) begin
          resp_model.delete();
        end
      end else if (!write && addr == `HCI_RESPONSE_PORT) begin
        void'(resp_model.pop_front());
      end
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Setup and access cycle with the check at mid access
  task automatic apb_access(input logic write, input logic [7:0] addr, input csr_word_t wdata);
    logic [32:0] expected;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    expected = ref_access(addr, write);
    check_value($sformatf("pslverr_o at 0x%h", addr), pslverr_o, expected[32]);
    if (!write) begin
      check_value($sformatf("prdata_o at 0x%h", addr), prdata_o, expected[31:0]);
    end
    model_commit(addr, write, wdata, expected[32]);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input csr_word_t wdata);
    apb_access(1'b1, addr, wdata);
  endtask

  task automatic apb_read(input logic [7:0] addr);
    apb_access(1'b0, addr, '0);
  endtask

  task automatic write_command(input csr_word_t w0, input csr_word_t w1);
    apb_write(`HCI_COMMAND_PORT, w0);
    apb_write(`HCI_COMMAND_PORT, w1);
  endtask

  task automatic push_response(input resp_desc_t data);
    logic accepted;
    int   t;
    accepted = 1'b0;
    @(posedge clk_i);
    resp_valid_i <= 1'b1;
    resp_data_i  <= data;
    for (t = 0; t < timeout_cycles && !accepted; t++) begin
      @(negedge clk_i);
      accepted = resp_ready_o;
      @(posedge clk_i);
    end
    resp_valid_i <= 1'b0;
    if (accepted) begin
      resp_model.push_back(data);
    end else begin
      errors++;
      $display("Timeout: response 0x%h was never accepted", data);
    end
  endtask

  task automatic check_triggers();
    int nc;
    int nr;
    @(negedge clk_i);
    nc = cmd_model.size();
    nr = resp_model.size();
    check_value("cmd_thld_trig_o", cmd_thld_trig_o, (depth - nc) >= cmd_thld_m);
    check_value("resp_thld_trig_o", resp_thld_trig_o, (nr != 0) && (nr >= resp_thld_m));
  endtask

  task automatic set_ready(input logic random_mode, input logic level);
    @(negedge clk_i);
    ready_random = random_mode;
    ready_hold   = level;
  endtask

  task automatic wait_cmd_drain();
    int t;
    t = 0;
    while (cmd_model.size() != 0 && t < timeout_cycles) begin
      @(posedge clk_i);
      t++;
    end
    if (cmd_model.size() != 0) begin
      errors++;
      $display("Timeout: %0d commands were never delivered", cmd_model.size());
    end
  endtask

  always @(posedge clk_i) begin
    ready_state = lcg_next(ready_state);
    cmd_ready_i <= ready_random ? ready_state[31] : ready_hold;
  end

  // Every command handshake against the head of the model
  always @(posedge clk_i) begin
    if (rst_ni && cmd_valid_o && cmd_ready_i) begin
      if (cmd_model.size() == 0) begin
        errors++;
        $display("Command 0x%h was delivered but none was expected", cmd_data_o);
      end else begin
        exp_desc = cmd_model.pop_front();
        check_value("cmd_data_o", cmd_data_o, exp_desc);
      end
    end
  end

  initial begin
    int          i;
    logic [31:0] w0;
    logic [31:0] w1;
    rst_ni       = 1'b0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    resp_valid_i = 1'b0;
    resp_data_i  = '0;
    errors       = 0;
    checks       = 0;
    lcg_state    = seed;
    ready_state  = seed;
    ready_random = 1'b0;
    ready_hold   = 1'b0;
    half_m       = '0;
    phase_m      = 1'b0;
    cmd_thld_m   = queue_thld_t'(`HCI_CMD_THLD_RST);
    resp_thld_m  = queue_thld_t'(`HCI_RESP_THLD_RST);
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset state
    @(negedge clk_i);
    check_value("cmd_valid_o", cmd_valid_o, 1'b0);
    check_value("resp_ready_o", resp_ready_o, 1'b1);
    check_triggers();
    apb_read(`HCI_QUEUE_STATUS);
    apb_read(`HCI_QUEUE_THLD_CTRL);
    apb_read(8'h14); // Unmapped

    // Commands under random back-pressure then a fill to full
    set_ready(1'b1, 1'b0);
    for (i = 0; i < 24; i++) begin
      w0 = next_rand();
      w1 = next_rand();
      write_command(w0, w1);
    end
    set_ready(1'b0, 1'b0);
    for (i = 0; i < 2 * depth && cmd_model.size() < depth; i++) begin
      w0 = next_rand();
      w1 = next_rand();
      write_command(w0, w1);
    end
    w0 = next_rand();
    w1 = next_rand();
    write_command(w0, w1); // Both words rejected by the full queue
    apb_read(`HCI_QUEUE_STATUS);
    set_ready(1'b0, 1'b1);
    wait_cmd_drain();
    set_ready(1'b0, 1'b0);
    apb_read(`HCI_QUEUE_STATUS);

    // Responses in order with the full and empty cases
    for (i = 0; i < depth; i++) begin
      push_response(next_rand());
    end
    @(negedge clk_i);
    check_value("resp_ready_o", resp_ready_o, 1'b0);
    apb_read(`HCI_QUEUE_STATUS);
    for (i = 0; i <= depth; i++) begin
      apb_read(`HCI_RESPONSE_PORT); // Last one hits the empty queue
    end

    // Threshold clamp and trigger tracking
    apb_write(`HCI_QUEUE_THLD_CTRL, 32'h0000_2828);
    apb_read(`HCI_QUEUE_THLD_CTRL);
    check_triggers();
    apb_write(`HCI_QUEUE_THLD_CTRL, 32'h0000_0304);
    for (i = 0; i < 14; i++) begin
      w0 = next_rand();
      w1 = next_rand();
      write_command(w0, w1);
      push_response(next_rand());
      check_triggers();
    end
    for (i = 0; i < 14; i++) begin
      apb_read(`HCI_RESPONSE_PORT);
      check_triggers();
    end
    set_ready(1'b0, 1'b1);
    wait_cmd_drain();
    set_ready(1'b0, 1'b0);
    check_triggers();

    // Empty response queue stays untriggered at threshold 0
    apb_write(`HCI_QUEUE_THLD_CTRL, 32'h0000_0000);
    check_triggers();
    push_response(next_rand());
    check_triggers();
    apb_read(`HCI_RESPONSE_PORT);

    // Flush both queues with a half-written command pending
    for (i = 0; i < 3; i++) begin
      w0 = next_rand();
      w1 = next_rand();
      write_command(w0, w1);
    end
    apb_write(`HCI_COMMAND_PORT, next_rand());
    push_response(next_rand());
    push_response(next_rand());
    apb_write(`HCI_RESET_CONTROL, 32'h0000_0003);
    apb_read(`HCI_QUEUE_STATUS);
    apb_read(`HCI_RESET_CONTROL);
    w0 = next_rand();
    w1 = next_rand();
    write_command(w0, w1);
    set_ready(1'b0, 1'b1);
    wait_cmd_drain();
    set_ready(1'b0, 1'b0);
    apb_read(`HCI_QUEUE_STATUS);

    repeat (4) @(posedge clk_i);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hci_queues.f
+incdir+.
hci_queues_pkg.sv
hci_csr_regs.sv
hci_cmd_queue.sv
hci_resp_queue.sv
hci_queues_top.sv
tb_hci_queues.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_hci_queues
FILELIST  := hci_queues.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hci_queues_defines.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
